// ==== hdl/riscv_pkg.sv ====
`default_nettype none

package riscv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [4:0]  cause_t;

    // RV32I major opcodes
    typedef enum logic [6:0] {
        OPC_LOAD     = 7'b0000011,
        OPC_MISC_MEM = 7'b0001111,
        OPC_OP_IMM   = 7'b0010011,
        OPC_AUIPC    = 7'b0010111,
        OPC_STORE    = 7'b0100011,
        OPC_OP       = 7'b0110011,
        OPC_LUI      = 7'b0110111,
        OPC_BRANCH   = 7'b1100011,
        OPC_JALR     = 7'b1100111,
        OPC_JAL      = 7'b1101111,
        OPC_SYSTEM   = 7'b1110011
    } opcode_e;

    // ALU funct3
    localparam funct3_t F3_ADD  = 3'b000;
    localparam funct3_t F3_SLL  = 3'b001;
    localparam funct3_t F3_SLT  = 3'b010;
    localparam funct3_t F3_SLTU = 3'b011;
    localparam funct3_t F3_XOR  = 3'b100;
    localparam funct3_t F3_SR   = 3'b101;
    localparam funct3_t F3_OR   = 3'b110;
    localparam funct3_t F3_AND  = 3'b111;

    // Branch funct3
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    localparam cause_t CAUSE_ILLEGAL          = 5'd2;
    localparam cause_t CAUSE_LOAD_MISALIGNED  = 5'd4;
    localparam cause_t CAUSE_LOAD_ACCESS      = 5'd5;
    localparam cause_t CAUSE_STORE_MISALIGNED = 5'd6;
    localparam cause_t CAUSE_STORE_ACCESS     = 5'd7;
    localparam cause_t CAUSE_LOAD_PAGE        = 5'd13;
    localparam cause_t CAUSE_STORE_PAGE       = 5'd15;

endpackage

`default_nettype wire

// ==== hdl/exec_pkg.sv ====
`default_nettype none

package exec_pkg;

    // Data cache command
    typedef enum logic [1:0] {
        CACHE_CMD_NONE  = 2'd0,
        CACHE_CMD_LOAD  = 2'd1,
        CACHE_CMD_STORE = 2'd2
    } cache_cmd_e;

    // Data cache response, anything but WAIT is final
    typedef enum logic [2:0] {
        CACHE_RESP_WAIT         = 3'd0,
        CACHE_RESP_DONE         = 3'd1,
        CACHE_RESP_MISALIGNED   = 3'd2,
        CACHE_RESP_ACCESS_FAULT = 3'd3,
        CACHE_RESP_PAGE_FAULT   = 3'd4
    } cache_resp_e;

    typedef enum logic [1:0] {
        E2F_IDLE         = 2'd0,
        E2F_BRANCH_TAKEN = 2'd1,
        E2F_EXC_START    = 2'd2
    } e2f_cmd_e;

    // Writeback source
    typedef enum logic [2:0] {
        RD_SEL_ALU       = 3'd0,
        RD_SEL_LUI       = 3'd1,
        RD_SEL_AUIPC     = 3'd2,
        RD_SEL_PC_PLUS_4 = 3'd3,
        RD_SEL_LOAD      = 3'd4
    } rd_sel_e;

endpackage

`default_nettype wire

// ==== hdl/rv_decoder.sv ====
`default_nettype none

module rv_decoder (
    input  riscv_pkg::instr_t    instr,
    output riscv_pkg::reg_addr_t rd_addr,
    output riscv_pkg::reg_addr_t rs1_addr,
    output riscv_pkg::reg_addr_t rs2_addr,
    output riscv_pkg::funct3_t   funct3,
    output logic                 funct7_alt,
    output logic                 is_op,
    output logic                 is_op_imm,
    output logic                 is_lui,
    output logic                 is_auipc,
    output logic                 is_jal,
    output logic                 is_jalr,
    output logic                 is_branch,
    output logic                 is_load,
    output logic                 is_store,
    output riscv_pkg::word_t     imm_i,
    output riscv_pkg::word_t     imm_s,
    output riscv_pkg::word_t     imm_b,
    output riscv_pkg::word_t     imm_u,
    output riscv_pkg::word_t     imm_j
);

    riscv_pkg::opcode_e opcode;
    logic               sign;

    assign opcode     = riscv_pkg::opcode_e'(instr[6:0]);
    assign rd_addr    = instr[11:7];
    assign funct3     = instr[14:12];
    assign rs1_addr   = instr[19:15];
    assign rs2_addr   = instr[24:20];
    assign funct7_alt = instr[30];
    assign sign       = instr[31];

    assign is_op     = opcode == riscv_pkg::OPC_OP;
    assign is_op_imm = opcode == riscv_pkg::OPC_OP_IMM;
    assign is_lui    = opcode == riscv_pkg::OPC_LUI;
    assign is_auipc  = opcode == riscv_pkg::OPC_AUIPC;
    assign is_jal    = opcode == riscv_pkg::OPC_JAL;
    assign is_jalr   = opcode == riscv_pkg::OPC_JALR;
    assign is_branch = opcode == riscv_pkg::OPC_BRANCH;
    assign is_load   = opcode == riscv_pkg::OPC_LOAD;
    // Only SB, SH and SW exist
    assign is_store  = (opcode == riscv_pkg::OPC_STORE) && !funct3[2];

    assign imm_i = {{20{sign}}, instr[31:20]};
    assign imm_s = {{20{sign}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{sign}}, sign, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'h000};
    assign imm_j = {{11{sign}}, sign, instr[19:12], instr[20], instr[30:21], 1'b0};

endmodule

`default_nettype wire

// ==== hdl/rv_alu.sv ====
`default_nettype none

module rv_alu (
    input  logic                 is_op,
    input  logic                 is_op_imm,
    input  riscv_pkg::funct3_t   funct3,
    input  logic                 funct7_alt,
    input  riscv_pkg::reg_addr_t shamt,
    input  riscv_pkg::word_t     rs1,
    input  riscv_pkg::word_t     rs2,
    input  riscv_pkg::word_t     imm_i,
    output riscv_pkg::word_t     result,
    output logic                 illegal
);

    riscv_pkg::word_t     operand_b;
    riscv_pkg::reg_addr_t sh;
    logic [6:0]           funct7;

    // Upper immediate bits double as funct7
    assign funct7    = imm_i[11:5];
    assign operand_b = is_op ? rs2 : imm_i;
    assign sh        = is_op ? rs2[4:0] : shamt;

    always_comb begin
        result = rs1 + operand_b;
        case (funct3)
            riscv_pkg::F3_ADD: begin
                // No SUBI, bit 30 is just part of the immediate there
                if (is_op && funct7_alt) begin
                    result = rs1 - operand_b;
                end
            end
            riscv_pkg::F3_SLL:  result = rs1 << sh;
            riscv_pkg::F3_SLT:  result = {31'b0, $signed(rs1) < $signed(operand_b)};
            riscv_pkg::F3_SLTU: result = {31'b0, rs1 < operand_b};
            riscv_pkg::F3_XOR:  result = rs1 ^ operand_b;
            riscv_pkg::F3_SR: begin
                if (funct7_alt) begin
                    result = riscv_pkg::word_t'($signed(rs1) >>> sh);
                end else begin
                    result = rs1 >> sh;
                end
            end
            riscv_pkg::F3_OR:   result = rs1 | operand_b;
            riscv_pkg::F3_AND:  result = rs1 & operand_b;
            default:            result = rs1 + operand_b;
        endcase
    end

    always_comb begin
        illegal = 1'b0;
        if (is_op) begin
            illegal = !((funct7 == 7'b0000000) ||
                        (funct7 == 7'b0100000 &&
                         (funct3 == riscv_pkg::F3_ADD || funct3 == riscv_pkg::F3_SR)));
        end else if (is_op_imm) begin
            if (funct3 == riscv_pkg::F3_SLL) begin
                illegal = funct7 != 7'b0000000;
            end else if (funct3 == riscv_pkg::F3_SR) begin
                illegal = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/rv_branch_cond.sv ====
`default_nettype none

module rv_branch_cond (
    input  riscv_pkg::funct3_t funct3,
    input  riscv_pkg::word_t   rs1,
    input  riscv_pkg::word_t   rs2,
    output logic               taken,
    output logic               illegal
);

    always_comb begin
        taken   = 1'b0;
        illegal = 1'b0;
        case (funct3)
            riscv_pkg::F3_BEQ:  taken = rs1 == rs2;
            riscv_pkg::F3_BNE:  taken = rs1 != rs2;
            riscv_pkg::F3_BLT:  taken = $signed(rs1) < $signed(rs2);
            riscv_pkg::F3_BGE:  taken = $signed(rs1) >= $signed(rs2);
            riscv_pkg::F3_BLTU: taken = rs1 < rs2;
            riscv_pkg::F3_BGEU: taken = rs1 >= rs2;
            // funct3 2 and 3
            default:            illegal = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/dcache_access.sv ====
`default_nettype none

module dcache_access (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   mem_start,
    input  logic                   is_store,
    input  exec_pkg::cache_resp_e  c_response,
    output exec_pkg::cache_cmd_e   c_cmd,
    output logic                   mem_done,
    output logic                   mem_error,
    output riscv_pkg::cause_t      mem_cause
);

    typedef enum logic {
        ST_IDLE,
        ST_ISSUED
    } state_e;

    state_e               state;
    state_e               state_nxt;
    exec_pkg::cache_cmd_e mem_cmd;

    assign mem_cmd = is_store ? exec_pkg::CACHE_CMD_STORE : exec_pkg::CACHE_CMD_LOAD;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Command goes out in the first cycle, responses count from the second
    always_comb begin
        state_nxt = state;
        c_cmd     = exec_pkg::CACHE_CMD_NONE;
        mem_done  = 1'b0;
        mem_error = 1'b0;
        case (state)
            ST_IDLE: begin
                if (mem_start) begin
                    c_cmd     = mem_cmd;
                    state_nxt = ST_ISSUED;
                end
            end
            ST_ISSUED: begin
                c_cmd = mem_cmd;
                case (c_response)
                    exec_pkg::CACHE_RESP_DONE: mem_done = 1'b1;
                    exec_pkg::CACHE_RESP_MISALIGNED,
                    exec_pkg::CACHE_RESP_ACCESS_FAULT,
                    exec_pkg::CACHE_RESP_PAGE_FAULT: mem_error = 1'b1;
                    default: mem_error = 1'b0;
                endcase
                if (mem_done || mem_error) begin
                    state_nxt = ST_IDLE;
                end
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    always_comb begin
        case (c_response)
            exec_pkg::CACHE_RESP_MISALIGNED: begin
                mem_cause = is_store ? riscv_pkg::CAUSE_STORE_MISALIGNED
                                     : riscv_pkg::CAUSE_LOAD_MISALIGNED;
            end
            exec_pkg::CACHE_RESP_PAGE_FAULT: begin
                mem_cause = is_store ? riscv_pkg::CAUSE_STORE_PAGE
                                     : riscv_pkg::CAUSE_LOAD_PAGE;
            end
            default: begin
                mem_cause = is_store ? riscv_pkg::CAUSE_STORE_ACCESS
                                     : riscv_pkg::CAUSE_LOAD_ACCESS;
            end
        endcase
    end

    // Fetch must hold the instruction while the cache stalls
    a_cmd_held: assert property (@(posedge clk) disable iff (!rst_n)
        (state == ST_ISSUED && c_response == exec_pkg::CACHE_RESP_WAIT)
        |=> c_cmd == $past(c_cmd));

endmodule

`default_nettype wire

// ==== hdl/execute_control.sv ====
`default_nettype none

module execute_control (
    input  logic                   clk,
    input  riscv_pkg::word_t       pc,
    input  riscv_pkg::word_t       rs1,
    input  riscv_pkg::reg_addr_t   rd_addr,
    input  logic                   is_op,
    input  logic                   is_op_imm,
    input  logic                   is_lui,
    input  logic                   is_auipc,
    input  logic                   is_jal,
    input  logic                   is_jalr,
    input  logic                   is_branch,
    input  logic                   is_load,
    input  logic                   is_store,
    input  riscv_pkg::word_t       imm_i,
    input  riscv_pkg::word_t       imm_s,
    input  riscv_pkg::word_t       imm_b,
    input  riscv_pkg::word_t       imm_u,
    input  riscv_pkg::word_t       imm_j,
    input  riscv_pkg::word_t       alu_result,
    input  logic                   alu_illegal,
    input  logic                   br_taken,
    input  logic                   br_illegal,
    input  riscv_pkg::funct3_t     funct3,
    input  logic                   mem_done,
    input  logic                   mem_error,
    input  riscv_pkg::cause_t      mem_cause,
    input  riscv_pkg::word_t       c_load_data,
    input  logic                   c_reset_done,
    output logic                   mem_start,
    output riscv_pkg::word_t       c_address,
    output logic                   e2f_ready,
    output exec_pkg::e2f_cmd_e     e2f_cmd,
    output riscv_pkg::word_t       e2f_branchtarget,
    output riscv_pkg::cause_t      exc_cause,
    output riscv_pkg::word_t       rd_wdata,
    output logic                   rd_write
);

    exec_pkg::rd_sel_e rd_sel;
    logic              illegal;
    logic              wb;
    riscv_pkg::word_t  jalr_sum;

    assign jalr_sum  = rs1 + imm_i;
    assign c_address = is_store ? rs1 + imm_s : rs1 + imm_i;

    always_comb begin
        e2f_ready        = 1'b0;
        e2f_cmd          = exec_pkg::E2F_IDLE;
        e2f_branchtarget = pc + imm_b;
        exc_cause        = '0;
        mem_start        = 1'b0;
        rd_sel           = exec_pkg::RD_SEL_ALU;
        wb               = 1'b0;
        illegal          = 1'b0;
        if (c_reset_done) begin
            e2f_ready = 1'b1;
            if (is_op || is_op_imm) begin
                wb      = 1'b1;
                illegal = alu_illegal;
            end else if (is_lui || is_auipc) begin
                wb     = 1'b1;
                rd_sel = is_lui ? exec_pkg::RD_SEL_LUI : exec_pkg::RD_SEL_AUIPC;
            end else if (is_jal) begin
                e2f_cmd          = exec_pkg::E2F_BRANCH_TAKEN;
                e2f_branchtarget = pc + imm_j;
                wb               = 1'b1;
                rd_sel           = exec_pkg::RD_SEL_PC_PLUS_4;
            end else if (is_jalr) begin
                illegal          = funct3 != 3'b000;
                e2f_cmd          = exec_pkg::E2F_BRANCH_TAKEN;
                e2f_branchtarget = {jalr_sum[31:1], 1'b0};
                wb               = 1'b1;
                rd_sel           = exec_pkg::RD_SEL_PC_PLUS_4;
            end else if (is_branch) begin
                illegal = br_illegal;
                if (br_taken) begin
                    e2f_cmd = exec_pkg::E2F_BRANCH_TAKEN;
                end
            end else if (is_load || is_store) begin
                // Stall until the cache gives a final response
                mem_start = 1'b1;
                e2f_ready = mem_done || mem_error;
                wb        = is_load && mem_done;
                rd_sel    = exec_pkg::RD_SEL_LOAD;
            end else begin
                illegal = 1'b1;
            end

            if (illegal) begin
                e2f_cmd   = exec_pkg::E2F_EXC_START;
                exc_cause = riscv_pkg::CAUSE_ILLEGAL;
                wb        = 1'b0;
            end else if (mem_error) begin
                e2f_cmd   = exec_pkg::E2F_EXC_START;
                exc_cause = mem_cause;
                wb        = 1'b0;
            end
        end
    end

    assign rd_write = wb && (rd_addr != '0);

    always_comb begin
        case (rd_sel)
            exec_pkg::RD_SEL_LUI:       rd_wdata = imm_u;
            exec_pkg::RD_SEL_AUIPC:     rd_wdata = pc + imm_u;
            exec_pkg::RD_SEL_PC_PLUS_4: rd_wdata = pc + 32'd4;
            exec_pkg::RD_SEL_LOAD:      rd_wdata = c_load_data;
            default:                    rd_wdata = alu_result;
        endcase
    end

    // Loads and stores retire only after their command was out for a cycle
    a_mem_retire: assert property (@(posedge clk)
        (e2f_ready && (is_load || is_store)) |-> $past(mem_start));

endmodule

`default_nettype wire

// ==== hdl/rv_execute.sv ====
`default_nettype none

module rv_execute (
    input  logic                   clk,
    input  logic                   rst_n,
    input  riscv_pkg::instr_t      instr,
    input  riscv_pkg::word_t       pc,
    input  riscv_pkg::word_t       rs1_data,
    input  riscv_pkg::word_t       rs2_data,
    output riscv_pkg::reg_addr_t   rs1_addr,
    output riscv_pkg::reg_addr_t   rs2_addr,
    output logic                   e2f_ready,
    output exec_pkg::e2f_cmd_e     e2f_cmd,
    output riscv_pkg::word_t       e2f_branchtarget,
    output riscv_pkg::cause_t      exc_cause,
    output exec_pkg::cache_cmd_e   c_cmd,
    output riscv_pkg::word_t       c_address,
    output riscv_pkg::funct3_t     c_load_type,
    output logic [1:0]             c_store_type,
    output riscv_pkg::word_t       c_store_data,
    input  riscv_pkg::word_t       c_load_data,
    input  exec_pkg::cache_resp_e  c_response,
    input  logic                   c_reset_done,
    output riscv_pkg::reg_addr_t   rd_addr,
    output riscv_pkg::word_t       rd_wdata,
    output logic                   rd_write
);

    riscv_pkg::funct3_t funct3;
    logic               funct7_alt;
    logic               is_op;
    logic               is_op_imm;
    logic               is_lui;
    logic               is_auipc;
    logic               is_jal;
    logic               is_jalr;
    logic               is_branch;
    logic               is_load;
    logic               is_store;
    riscv_pkg::word_t   imm_i;
    riscv_pkg::word_t   imm_s;
    riscv_pkg::word_t   imm_b;
    riscv_pkg::word_t   imm_u;
    riscv_pkg::word_t   imm_j;
    riscv_pkg::word_t   alu_result;
    logic               alu_illegal;
    logic               br_taken;
    logic               br_illegal;
    logic               mem_start;
    logic               mem_done;
    logic               mem_error;
    riscv_pkg::cause_t  mem_cause;
    logic               stage_enable;

    assign c_load_type  = funct3;
    assign c_store_type = funct3[1:0];
    assign c_store_data = rs2_data;

    // Stage idles in reset and while the cache initializes
    assign stage_enable = rst_n && c_reset_done;

    rv_decoder u_decoder (
        .instr      (instr),
        .rd_addr    (rd_addr),
        .rs1_addr   (rs1_addr),
        .rs2_addr   (rs2_addr),
        .funct3     (funct3),
        .funct7_alt (funct7_alt),
        .is_op      (is_op),
        .is_op_imm  (is_op_imm),
        .is_lui     (is_lui),
        .is_auipc   (is_auipc),
        .is_jal     (is_jal),
        .is_jalr    (is_jalr),
        .is_branch  (is_branch),
        .is_load    (is_load),
        .is_store   (is_store),
        .imm_i      (imm_i),
        .imm_s      (imm_s),
        .imm_b      (imm_b),
        .imm_u      (imm_u),
        .imm_j      (imm_j)
    );

    rv_alu u_alu (
        .is_op      (is_op),
        .is_op_imm  (is_op_imm),
        .funct3     (funct3),
        .funct7_alt (funct7_alt),
        .shamt      (rs2_addr),
        .rs1        (rs1_data),
        .rs2        (rs2_data),
        .imm_i      (imm_i),
        .result     (alu_result),
        .illegal    (alu_illegal)
    );

    rv_branch_cond u_branch_cond (
        .funct3  (funct3),
        .rs1     (rs1_data),
        .rs2     (rs2_data),
        .taken   (br_taken),
        .illegal (br_illegal)
    );

    dcache_access u_dcache_access (
        .clk        (clk),
        .rst_n      (rst_n),
        .mem_start  (mem_start),
        .is_store   (is_store),
        .c_response (c_response),
        .c_cmd      (c_cmd),
        .mem_done   (mem_done),
        .mem_error  (mem_error),
        .mem_cause  (mem_cause)
    );

    execute_control u_control (
        .clk              (clk),
        .pc               (pc),
        .rs1              (rs1_data),
        .rd_addr          (rd_addr),
        .is_op            (is_op),
        .is_op_imm        (is_op_imm),
        .is_lui           (is_lui),
        .is_auipc         (is_auipc),
        .is_jal           (is_jal),
        .is_jalr          (is_jalr),
        .is_branch        (is_branch),
        .is_load          (is_load),
        .is_store         (is_store),
        .imm_i            (imm_i),
        .imm_s            (imm_s),
        .imm_b            (imm_b),
        .imm_u            (imm_u),
        .imm_j            (imm_j),
        .alu_result       (alu_result),
        .alu_illegal      (alu_illegal),
        .br_taken         (br_taken),
        .br_illegal       (br_illegal),
        .funct3           (funct3),
        .mem_done         (mem_done),
        .mem_error        (mem_error),
        .mem_cause        (mem_cause),
        .c_load_data      (c_load_data),
        .c_reset_done     (stage_enable),
        .mem_start        (mem_start),
        .c_address        (c_address),
        .e2f_ready        (e2f_ready),
        .e2f_cmd          (e2f_cmd),
        .e2f_branchtarget (e2f_branchtarget),
        .exc_cause        (exc_cause),
        .rd_wdata         (rd_wdata),
        .rd_write         (rd_write)
    );

endmodule

`default_nettype wire

// ==== sim/rv_execute_vectors.svh ====
`ifndef RV_EXECUTE_VECTORS_SVH
`define RV_EXECUTE_VECTORS_SVH

// instr, pc, rs1_data, rs2_data, response (1 done 2 misaligned 3 access 4 page), load data,
// address, e2f_cmd (0 idle 1 taken 2 exc), target, cause, rd_write, rd_wdata,
// rd_addr, rs1_addr, rs2_addr
task automatic load_vectors();
    // add, sub, slt, sra, xori
    add_vector(32'h002081B3, 32'h00000000, 32'h00000005, 32'h00000007, 0, 32'h0,
               32'h0, 0, 32'h0, 0, 1, 32'h0000000C, 3, 1, 2);
    add_vector(32'h402081B3, 32'h00000000, 32'h00000005, 32'h00000007, 0, 32'h0,
               32'h0, 0, 32'h0, 0, 1, 32'hFFFFFFFE, 3, 1, 2);
    add_vector(32'h0020A1B3, 32'h00000000, 32'hFFFFFFFF, 32'h00000001, 0, 32'h0,
               32'h0, 0, 32'h0, 0, 1, 32'h00000001, 3, 1, 2);
    add_vector(32'h4020D1B3, 32'h00000000, 32'h80000000, 32'h00000004, 0, 32'h0,
               32'h0, 0, 32'h0, 0, 1, 32'hF8000000, 3, 1, 2);
    add_vector(32'h0FF0C213, 32'h00000000, 32'h0000F0F0, 32'h00000000, 0, 32'h0,
               32'h0, 0, 32'h0, 0, 1, 32'h0000F00F, 4, 1, 31);
    // Destination x0
    add_vector(32'h00208033, 32'h00000000, 32'h00000005, 32'h00000007, 0, 32'h0,
               32'h0, 0, 32'h0, 0, 0, 32'h0, 0, 1, 2);
    // lui, auipc
    add_vector(32'h123452B7, 32'h00000000, 32'h00000000, 32'h00000000, 0, 32'h0,
               32'h0, 0, 32'h0, 0, 1, 32'h12345000, 5, 8, 3);
    add_vector(32'h00001317, 32'h00000100, 32'h00000000, 32'h00000000, 0, 32'h0,
               32'h0, 0, 32'h0, 0, 1, 32'h00001100, 6, 0, 0);
    // beq taken, bne not taken, blt backwards
    add_vector(32'h00208863, 32'h00000200, 32'h00000009, 32'h00000009, 0, 32'h0,
               32'h0, 1, 32'h00000210, 0, 0, 32'h0, 16, 1, 2);
    add_vector(32'h00209863, 32'h00000200, 32'h00000009, 32'h00000009, 0, 32'h0,
               32'h0, 0, 32'h0, 0, 0, 32'h0, 16, 1, 2);
    add_vector(32'hFE20CCE3, 32'h00000300, 32'hFFFFFFF0, 32'h00000003, 0, 32'h0,
               32'h0, 1, 32'h000002F8, 0, 0, 32'h0, 25, 1, 2);
    // jal, jalr with odd sum
    add_vector(32'h001000EF, 32'h00000400, 32'h00000000, 32'h00000000, 0, 32'h0,
               32'h0, 1, 32'h00000C00, 0, 1, 32'h00000404, 1, 0, 1);
    add_vector(32'h005100E7, 32'h00000500, 32'h00001000, 32'h00000000, 0, 32'h0,
               32'h0, 1, 32'h00001004, 0, 1, 32'h00000504, 1, 2, 5);
    // lw and sw
    add_vector(32'h0080A383, 32'h00000600, 32'h00002000, 32'h00000000, 1, 32'hDEADBEEF,
               32'h00002008, 0, 32'h0, 0, 1, 32'hDEADBEEF, 7, 1, 8);
    add_vector(32'h0020A623, 32'h00000604, 32'h00003000, 32'h0BADF00D, 1, 32'h0,
               32'h0000300C, 0, 32'h0, 0, 0, 32'h0, 12, 1, 2);
    // Cache errors
    add_vector(32'h0080A383, 32'h00000608, 32'h00004000, 32'h00000000, 4, 32'h0,
               32'h00004008, 2, 32'h0, 13, 0, 32'h0, 7, 1, 8);
    add_vector(32'h0080A383, 32'h0000060C, 32'h00004001, 32'h00000000, 2, 32'h0,
               32'h00004009, 2, 32'h0, 4, 0, 32'h0, 7, 1, 8);
    add_vector(32'h0080A383, 32'h00000610, 32'h00005000, 32'h00000000, 3, 32'h0,
               32'h00005008, 2, 32'h0, 5, 0, 32'h0, 7, 1, 8);
    add_vector(32'h0020A623, 32'h00000614, 32'h00006000, 32'h00000000, 3, 32'h0,
               32'h0000600C, 2, 32'h0, 7, 0, 32'h0, 12, 1, 2);
    add_vector(32'h0020A623, 32'h00000618, 32'h00006002, 32'h00000000, 2, 32'h0,
               32'h0000600E, 2, 32'h0, 6, 0, 32'h0, 12, 1, 2);
    // Illegal ecall, branch funct3 2 and funct7 1
    add_vector(32'h00000073, 32'h00000700, 32'h00000000, 32'h00000000, 0, 32'h0,
               32'h0, 2, 32'h0, 2, 0, 32'h0, 0, 0, 0);
    add_vector(32'h0020A063, 32'h00000704, 32'h00000001, 32'h00000002, 0, 32'h0,
               32'h0, 2, 32'h0, 2, 0, 32'h0, 0, 1, 2);
    add_vector(32'h022081B3, 32'h00000708, 32'h00000005, 32'h00000007, 0, 32'h0,
               32'h0, 2, 32'h0, 2, 0, 32'h0, 3, 1, 2);
endtask

`endif

// ==== sim/rv_execute_tb.sv ====
`default_nettype none

module rv_execute_tb;

    localparam int MAX_VEC = 32;
    localparam int TIMEOUT = 50;

    logic                  clk;
    logic                  rst_n;
    riscv_pkg::instr_t     instr;
    riscv_pkg::word_t      pc;
    riscv_pkg::word_t      rs1_data;
    riscv_pkg::word_t      rs2_data;
    riscv_pkg::reg_addr_t  rs1_addr;
    riscv_pkg::reg_addr_t  rs2_addr;
    logic                  e2f_ready;
    exec_pkg::e2f_cmd_e    e2f_cmd;
    riscv_pkg::word_t      e2f_branchtarget;
    riscv_pkg::cause_t     exc_cause;
    exec_pkg::cache_cmd_e  c_cmd;
    riscv_pkg::word_t      c_address;
    riscv_pkg::funct3_t    c_load_type;
    logic [1:0]            c_store_type;
    riscv_pkg::word_t      c_store_data;
    riscv_pkg::word_t      c_load_data;
    exec_pkg::cache_resp_e c_response;
    logic                  c_reset_done;
    riscv_pkg::reg_addr_t  rd_addr;
    riscv_pkg::word_t      rd_wdata;
    logic                  rd_write;

    riscv_pkg::word_t v_instr[MAX_VEC];
    riscv_pkg::word_t v_pc[MAX_VEC];
    riscv_pkg::word_t v_rs1[MAX_VEC];
    riscv_pkg::word_t v_rs2[MAX_VEC];
    logic [2:0]       v_resp[MAX_VEC];
    riscv_pkg::word_t v_load[MAX_VEC];
    riscv_pkg::word_t v_addr[MAX_VEC];
    logic [1:0]       v_cmd[MAX_VEC];
    riscv_pkg::word_t v_target[MAX_VEC];
    logic [4:0]       v_cause[MAX_VEC];
    logic             v_write[MAX_VEC];
    riscv_pkg::word_t v_wdata[MAX_VEC];
    logic [4:0]       v_rd_addr[MAX_VEC];
    logic [4:0]       v_rs1_addr[MAX_VEC];
    logic [4:0]       v_rs2_addr[MAX_VEC];

    int n_vec = 0;
    int errors = 0;
    int row_errors = 0;
    int cur_row = 0;

    rv_execute u_rv_execute (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic add_vector(input logic [31:0] i_instr, input logic [31:0] i_pc,
                              input logic [31:0] i_rs1, input logic [31:0] i_rs2,
                              input logic [2:0] i_resp, input logic [31:0] i_load,
                              input logic [31:0] i_addr, input logic [1:0] i_cmd,
                              input logic [31:0] i_target, input logic [4:0] i_cause,
                              input logic i_write, input logic [31:0] i_wdata,
                              input logic [4:0] i_rd, input logic [4:0] i_rs1a,
                              input logic [4:0] i_rs2a);
        v_instr[n_vec]    = i_instr;
        v_pc[n_vec]       = i_pc;
        v_rs1[n_vec]      = i_rs1;
        v_rs2[n_vec]      = i_rs2;
        v_resp[n_vec]     = i_resp;
        v_load[n_vec]     = i_load;
        v_addr[n_vec]     = i_addr;
        v_cmd[n_vec]      = i_cmd;
        v_target[n_vec]   = i_target;
        v_cause[n_vec]    = i_cause;
        v_write[n_vec]    = i_write;
        v_wdata[n_vec]    = i_wdata;
        v_rd_addr[n_vec]  = i_rd;
        v_rs1_addr[n_vec] = i_rs1a;
        v_rs2_addr[n_vec] = i_rs2a;
        n_vec++;
    endtask

`include "rv_execute_vectors.svh"

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] row %0d %s got 0x%08h expected 0x%08h", cur_row, name, got, exp);
            row_errors++;
        end
    endtask

    initial begin
        int   cycles;
        int   wait_left;
        logic seen;

        void'($urandom(11467));
        rst_n        = 1'b0;
        instr        = 32'h00000013;
        pc           = '0;
        rs1_data     = '0;
        rs2_data     = '0;
        c_load_data  = '0;
        c_response   = exec_pkg::CACHE_RESP_WAIT;
        c_reset_done = 1'b0;
        load_vectors();

        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // A held add must not complete while the cache initializes
        cur_row    = -1;
        row_errors = 0;
        instr      = 32'h002081B3;
        rs1_data   = 32'd5;
        rs2_data   = 32'd7;
        for (int k = 0; k < 4; k++) begin
            @(negedge clk);
            #1;
            check_word("e2f_ready", e2f_ready, 1'b0);
            check_word("rd_write", rd_write, 1'b0);
        end
        c_reset_done = 1'b1;
        #1;
        check_word("e2f_ready", e2f_ready, 1'b1);
        $display("reset_done hold: %s", row_errors == 0 ? "ok" : "errors");
        errors += row_errors;

        for (int i = 0; i < n_vec; i++) begin
            @(negedge clk);
            cur_row     = i;
            row_errors  = 0;
            instr       = v_instr[i];
            pc          = v_pc[i];
            rs1_data    = v_rs1[i];
            rs2_data    = v_rs2[i];
            c_load_data = v_load[i];
            c_response  = exec_pkg::CACHE_RESP_WAIT;
            wait_left   = $urandom % 6;
            seen        = 1'b0;
            cycles      = 0;
            #1;
            while (cycles < TIMEOUT) begin
                if (c_cmd != exec_pkg::CACHE_CMD_NONE && !seen) begin
                    seen = 1'b1;
                    if (v_resp[i] == 3'd0) begin
                        $display("row %0d: cache command from a non-memory instruction", i);
                        row_errors++;
                    end
                    check_word("c_cmd", c_cmd, (v_instr[i][6:0] == 7'b0100011) ?
                               exec_pkg::CACHE_CMD_STORE : exec_pkg::CACHE_CMD_LOAD);
                    check_word("c_address", c_address, v_addr[i]);
                    check_word("c_store_data", c_store_data, v_rs2[i]);
                    check_word("c_load_type", c_load_type, v_instr[i][14:12]);
                    check_word("c_store_type", c_store_type, v_instr[i][13:12]);
                end
                if (e2f_ready) begin
                    break;
                end
                @(negedge clk);
                if (seen) begin
                    if (wait_left == 0) begin
                        c_response = exec_pkg::cache_resp_e'(v_resp[i]);
                    end else begin
                        wait_left--;
                    end
                end
                #1;
                cycles++;
            end
            if (!e2f_ready) begin
                $display("row %0d: e2f_ready did not rise within %0d cycles", i, TIMEOUT);
                $display("TESTBENCH FAILED");
                $finish;
            end
            if (!seen && cycles != 0) begin
                $display("row %0d: instruction without cache access took %0d cycles", i, cycles);
                row_errors++;
            end
            if (v_resp[i] != 3'd0 && c_response == exec_pkg::CACHE_RESP_WAIT) begin
                $display("row %0d: load or store completed before the cache responded", i);
                row_errors++;
            end
            check_word("rd_addr", rd_addr, v_rd_addr[i]);
            check_word("rs1_addr", rs1_addr, v_rs1_addr[i]);
            check_word("rs2_addr", rs2_addr, v_rs2_addr[i]);
            check_word("e2f_cmd", e2f_cmd, v_cmd[i]);
            if (v_cmd[i] == 2'd1) begin
                check_word("e2f_branchtarget", e2f_branchtarget, v_target[i]);
            end
            if (v_cmd[i] == 2'd2) begin
                check_word("exc_cause", exc_cause, v_cause[i]);
            end
            check_word("rd_write", rd_write, v_write[i]);
            if (v_write[i]) begin
                check_word("rd_wdata", rd_wdata, v_wdata[i]);
            end
            $display("row %0d instr 0x%08h: %s", i, v_instr[i], row_errors == 0 ? "ok" : "errors");
            errors += row_errors;
        end

        $display("rows run: %0d, errors: %0d", n_vec + 1, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rv_execute.f ====
+incdir+sim
hdl/riscv_pkg.sv
hdl/exec_pkg.sv
hdl/rv_decoder.sv
hdl/rv_alu.sv
hdl/rv_branch_cond.sv
hdl/dcache_access.sv
hdl/execute_control.sv
hdl/rv_execute.sv
sim/rv_execute_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= rv_execute_tb
FILELIST  ?= rv_execute.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf $(OBJ_DIR)
